// File: source/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Datapath and address widths.
`define LSU_XLEN    64
`define LSU_ALEN    32
`define LSU_BLEN    (`LSU_XLEN/8)

// Atomic operation field.
`define AMO_OP_LEN  4

`define AMO_SWAP    4'h0
`define AMO_ADD     4'h1
`define AMO_XOR     4'h2
`define AMO_AND     4'h3
`define AMO_OR      4'h4
`define AMO_MIN     4'h5
`define AMO_MAX     4'h6
`define AMO_MINU    4'h7
`define AMO_MAXU    4'h8

`endif

// File: source/lsu_pkg.sv
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

    // Memory word seen whole or as two words, indexed by address bit 2.
    typedef union packed {
        logic [`LSU_XLEN-1:0]           d;
        logic [1:0][`LSU_XLEN/2-1:0]    w;
    } dword_u;

endpackage

`default_nettype wire

// File: source/lsu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module lsu_ctrl (
    input  logic                    clk,
    input  logic                    rstn,

    input  logic                    req_i,
    input  logic                    wr_i,
    input  logic                    ex_i,
    input  logic                    amo_i,
    input  logic [`LSU_BLEN-1:0]    byte_i,
    input  logic [`LSU_ALEN-1:0]    addr_i,
    input  logic [1:0]              dmem_bad_i,
    input  logic                    dmem_busy_i,

    output logic                    accept_o,
    output logic                    resp_o,
    output logic                    amo_wr_o,
    output logic                    sc_resp_o,
    output logic                    load_resp_o,
    output logic                    hazard_o,
    output logic                    fault_o,
    output logic                    load_misaligned_o,
    output logic                    store_misaligned_o,
    output logic                    load_pg_fault_o,
    output logic                    store_pg_fault_o,
    output logic                    load_xes_fault_o,
    output logic                    store_xes_fault_o,

    output logic                    dmem_req_o,
    output logic [`LSU_ALEN-1:0]    dmem_addr_o,
    output logic                    dmem_wr_o,
    output logic                    dmem_ex_o
);

    logic                   misaligned;
    logic                   accept;
    logic                   resp;
    logic                   mem_bad;
    logic                   amo_issue;
    logic                   done;

    logic                   pend_q;
    logic                   amo_rd_q;
    logic                   amo_wr_q;
    logic                   load_q;
    logic                   store_q;
    logic                   sc_q;
    logic [`LSU_ALEN-1:0]   addr_q;

    assign misaligned = (addr_i[0] & byte_i[1]) |
                        (addr_i[1] & byte_i[3]) |
                        (addr_i[2] & byte_i[7]);

    assign accept    = req_i & ~misaligned & ~dmem_busy_i & ~pend_q;
    assign resp      = pend_q & ~dmem_busy_i;
    assign mem_bad   = resp & |dmem_bad_i;
    // Write phase goes out in the read response cycle, unless it faulted.
    assign amo_issue = resp & amo_rd_q & ~|dmem_bad_i;
    assign done      = resp & ~amo_issue;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend_q   <= 1'b0;
            amo_rd_q <= 1'b0;
            amo_wr_q <= 1'b0;
        end else if (accept) begin
            pend_q   <= 1'b1;
            amo_rd_q <= amo_i;
            amo_wr_q <= 1'b0;
        end else if (amo_issue) begin
            amo_rd_q <= 1'b0;
            amo_wr_q <= 1'b1;
        end else if (done) begin
            pend_q   <= 1'b0;
            amo_rd_q <= 1'b0;
            amo_wr_q <= 1'b0;
        end
    end

    // Kind of the access in flight; atomics report as stores.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_q  <= 1'b0;
            store_q <= 1'b0;
            sc_q    <= 1'b0;
        end else if (accept) begin
            load_q  <= ~wr_i & ~amo_i;
            store_q <= wr_i | amo_i;
            sc_q    <= ex_i & wr_i & ~amo_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr_i;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_misaligned_o  <= 1'b0;
            store_misaligned_o <= 1'b0;
        end else begin
            load_misaligned_o  <= req_i & misaligned & ~wr_i & ~amo_i;
            store_misaligned_o <= req_i & misaligned & (wr_i | amo_i);
        end
    end

    assign accept_o    = accept;
    assign resp_o      = resp;
    assign load_resp_o = load_q | amo_rd_q;
    assign sc_resp_o   = sc_q;
    assign amo_wr_o    = amo_issue | amo_wr_q;

    assign dmem_req_o  = accept | amo_issue;
    assign dmem_addr_o = amo_wr_o ? addr_q : addr_i;
    assign dmem_wr_o   = amo_wr_o | (wr_i & ~amo_i);
    assign dmem_ex_o   = amo_wr_o | ex_i | amo_i;

    assign hazard_o = (pend_q & ~done) | (req_i & ~misaligned & ~pend_q);

    assign load_pg_fault_o   = resp & dmem_bad_i[0] & load_q;
    assign store_pg_fault_o  = resp & dmem_bad_i[0] & store_q;
    assign load_xes_fault_o  = resp & dmem_bad_i[1] & load_q;
    assign store_xes_fault_o = resp & dmem_bad_i[1] & store_q;
    assign fault_o           = mem_bad | load_misaligned_o | store_misaligned_o;

endmodule

`default_nettype wire

// File: source/store_align.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module store_align (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    accept_i,
    input  logic                    amo_wr_i,
    input  logic [`LSU_BLEN-1:0]    byte_i,
    input  logic [`LSU_ALEN-1:0]    addr_i,
    input  logic [`LSU_XLEN-1:0]    wdata_i,
    input  logic [`LSU_XLEN-1:0]    amo_wdata_i,
    output logic [`LSU_BLEN-1:0]    dmem_byte_o,
    output logic [`LSU_XLEN-1:0]    dmem_wdata_o
);

    import lsu_pkg::*;

    localparam int OFF_W = $clog2(`LSU_BLEN);

    logic [`LSU_BLEN-1:0]   byte_q;
    logic                   hi_q;
    dword_u                 amo_word;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            byte_q <= '0;
            hi_q   <= 1'b0;
        end else if (accept_i) begin
            byte_q <= byte_i;
            hi_q   <= addr_i[2];
        end
    end

    always_comb begin
        amo_word = amo_wdata_i;
        // Word result lands in the addressed half.
        if (!byte_q[`LSU_BLEN-1]) begin
            amo_word.w[hi_q] = amo_wdata_i[`LSU_XLEN/2-1:0];
        end
        if (amo_wr_i) begin
            dmem_byte_o  = byte_q << {hi_q, 2'b00};
            dmem_wdata_o = amo_word;
        end else begin
            dmem_byte_o  = byte_i << addr_i[OFF_W-1:0];
            dmem_wdata_o = wdata_i << {addr_i[OFF_W-1:0], 3'b000};
        end
    end

endmodule

`default_nettype wire

// File: source/load_align.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module load_align (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    accept_i,
    input  logic                    resp_i,
    input  logic                    load_resp_i,
    input  logic                    sc_resp_i,
    input  logic [`LSU_BLEN-1:0]    byte_i,
    input  logic [`LSU_ALEN-1:0]    addr_i,
    input  logic                    sign_ext_i,
    input  logic [`LSU_XLEN-1:0]    dmem_rdata_i,
    input  logic                    dmem_xstate_i,
    output logic [`LSU_XLEN-1:0]    rdata_o
);

    import lsu_pkg::*;

    localparam int OFF_W = $clog2(`LSU_BLEN);

    logic [OFF_W-1:0]       off_q;
    logic [`LSU_BLEN-1:0]   byte_q;
    logic                   sext_q;
    dword_u                 shft;
    logic [`LSU_XLEN-1:0]   ext;
    logic [`LSU_XLEN-1:0]   sc_res;
    logic [`LSU_XLEN-1:0]   data_q;

    // Access shape of the request in flight.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            off_q  <= '0;
            byte_q <= '0;
            sext_q <= 1'b0;
        end else if (accept_i) begin
            off_q  <= addr_i[OFF_W-1:0];
            byte_q <= byte_i;
            sext_q <= sign_ext_i;
        end
    end

    assign shft = dmem_rdata_i >> {off_q, 3'b000};

    always_comb begin
        if (byte_q[7]) begin
            ext = shft.d;
        end else if (byte_q[3]) begin
            ext = {{(`LSU_XLEN-32){sext_q & shft.w[0][31]}}, shft.w[0]};
        end else if (byte_q[1]) begin
            ext = {{(`LSU_XLEN-16){sext_q & shft.d[15]}}, shft.d[15:0]};
        end else begin
            ext = {{(`LSU_XLEN-8){sext_q & shft.d[7]}}, shft.d[7:0]};
        end
    end

    // Zero on success.
    assign sc_res = {{(`LSU_XLEN-1){1'b0}}, ~dmem_xstate_i};

    always_comb begin
        if (resp_i & sc_resp_i) begin
            rdata_o = sc_res;
        end else if (resp_i & load_resp_i) begin
            rdata_o = ext;
        end else begin
            rdata_o = data_q;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_i & (sc_resp_i | load_resp_i)) begin
            data_q <= rdata_o;
        end
    end

endmodule

`default_nettype wire

// File: source/amo_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module amo_alu (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    accept_i,
    input  logic [`AMO_OP_LEN-1:0]  amo_op_i,
    input  logic                    amo_64_i,
    input  logic [`LSU_ALEN-1:0]    addr_i,
    input  logic [`LSU_XLEN-1:0]    wdata_i,
    input  logic [`LSU_XLEN-1:0]    dmem_rdata_i,
    output logic [`LSU_XLEN-1:0]    amo_wdata_o
);

    import lsu_pkg::*;

    logic [`AMO_OP_LEN-1:0] op_q;
    logic                   a64_q;
    logic                   hi_q;
    logic [`LSU_XLEN-1:0]   src_q;
    dword_u                 mem;
    logic [`LSU_XLEN-1:0]   mem_val;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op_q  <= `AMO_SWAP;
            a64_q <= 1'b0;
            hi_q  <= 1'b0;
        end else if (accept_i) begin
            op_q  <= amo_op_i;
            a64_q <= amo_64_i;
            hi_q  <= addr_i[2];
        end
    end

    // Word operands are kept sign-extended.
    always_ff @(posedge clk) begin
        if (accept_i) begin
            src_q <= amo_64_i ? wdata_i :
                     {{(`LSU_XLEN-32){wdata_i[31]}}, wdata_i[31:0]};
        end
    end

    assign mem     = dmem_rdata_i;
    assign mem_val = a64_q ? mem.d : {{(`LSU_XLEN-32){mem.w[hi_q][31]}}, mem.w[hi_q]};

    // Unsigned compare stays correct on sign-extended words.
    always_comb begin
        case (op_q)
            `AMO_SWAP: amo_wdata_o = src_q;
            `AMO_ADD:  amo_wdata_o = mem_val + src_q;
            `AMO_XOR:  amo_wdata_o = mem_val ^ src_q;
            `AMO_AND:  amo_wdata_o = mem_val & src_q;
            `AMO_OR:   amo_wdata_o = mem_val | src_q;
            `AMO_MIN:  amo_wdata_o = ($signed(mem_val) < $signed(src_q)) ? mem_val : src_q;
            `AMO_MAX:  amo_wdata_o = ($signed(mem_val) > $signed(src_q)) ? mem_val : src_q;
            `AMO_MINU: amo_wdata_o = (mem_val < src_q) ? mem_val : src_q;
            `AMO_MAXU: amo_wdata_o = (mem_val > src_q) ? mem_val : src_q;
            default:   amo_wdata_o = src_q;
        endcase
    end

endmodule

`default_nettype wire

// File: source/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module lsu_top (
    input  logic                    clk,
    input  logic                    rstn,

    input  logic                    req_i,
    input  logic                    wr_i,
    input  logic                    ex_i,
    input  logic                    amo_i,
    input  logic                    amo_64_i,
    input  logic                    sign_ext_i,
    input  logic [`AMO_OP_LEN-1:0]  amo_op_i,
    input  logic [`LSU_BLEN-1:0]    byte_i,
    input  logic [`LSU_ALEN-1:0]    addr_i,
    input  logic [`LSU_XLEN-1:0]    wdata_i,

    output logic                    amo_wr_o,
    output logic [`LSU_XLEN-1:0]    rdata_o,
    output logic                    hazard_o,

    output logic                    fault_o,
    output logic                    load_misaligned_o,
    output logic                    store_misaligned_o,
    output logic                    load_pg_fault_o,
    output logic                    store_pg_fault_o,
    output logic                    load_xes_fault_o,
    output logic                    store_xes_fault_o,

    output logic                    dmem_req_o,
    output logic [`LSU_ALEN-1:0]    dmem_addr_o,
    output logic                    dmem_wr_o,
    output logic                    dmem_ex_o,
    output logic [`LSU_BLEN-1:0]    dmem_byte_o,
    output logic [`LSU_XLEN-1:0]    dmem_wdata_o,
    input  logic [`LSU_XLEN-1:0]    dmem_rdata_i,
    input  logic [1:0]              dmem_bad_i,
    input  logic                    dmem_xstate_i,
    input  logic                    dmem_busy_i
);

    logic                   accept;
    logic                   resp;
    logic                   sc_resp;
    logic                   load_resp;
    logic [`LSU_XLEN-1:0]   amo_wdata;

    lsu_ctrl u_ctrl (
        .clk                (clk),
        .rstn               (rstn),
        .req_i              (req_i),
        .wr_i               (wr_i),
        .ex_i               (ex_i),
        .amo_i              (amo_i),
        .byte_i             (byte_i),
        .addr_i             (addr_i),
        .dmem_bad_i         (dmem_bad_i),
        .dmem_busy_i        (dmem_busy_i),
        .accept_o           (accept),
        .resp_o             (resp),
        .amo_wr_o           (amo_wr_o),
        .sc_resp_o          (sc_resp),
        .load_resp_o        (load_resp),
        .hazard_o           (hazard_o),
        .fault_o            (fault_o),
        .load_misaligned_o  (load_misaligned_o),
        .store_misaligned_o (store_misaligned_o),
        .load_pg_fault_o    (load_pg_fault_o),
        .store_pg_fault_o   (store_pg_fault_o),
        .load_xes_fault_o   (load_xes_fault_o),
        .store_xes_fault_o  (store_xes_fault_o),
        .dmem_req_o         (dmem_req_o),
        .dmem_addr_o        (dmem_addr_o),
        .dmem_wr_o          (dmem_wr_o),
        .dmem_ex_o          (dmem_ex_o)
    );

    store_align u_store_align (
        .clk          (clk),
        .rstn         (rstn),
        .accept_i     (accept),
        .amo_wr_i     (amo_wr_o),
        .byte_i       (byte_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .amo_wdata_i  (amo_wdata),
        .dmem_byte_o  (dmem_byte_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

    load_align u_load_align (
        .clk           (clk),
        .rstn          (rstn),
        .accept_i      (accept),
        .resp_i        (resp),
        .load_resp_i   (load_resp),
        .sc_resp_i     (sc_resp),
        .byte_i        (byte_i),
        .addr_i        (addr_i),
        .sign_ext_i    (sign_ext_i),
        .dmem_rdata_i  (dmem_rdata_i),
        .dmem_xstate_i (dmem_xstate_i),
        .rdata_o       (rdata_o)
    );

    amo_alu u_amo_alu (
        .clk          (clk),
        .rstn         (rstn),
        .accept_i     (accept),
        .amo_op_i     (amo_op_i),
        .amo_64_i     (amo_64_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .dmem_rdata_i (dmem_rdata_i),
        .amo_wdata_o  (amo_wdata)
    );

endmodule

`default_nettype wire

// File: tests/dmem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module dmem_model (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    stall_en_i,
    input  logic                    req_i,
    input  logic [`LSU_ALEN-1:0]    addr_i,
    input  logic                    wr_i,
    input  logic                    ex_i,
    input  logic [`LSU_BLEN-1:0]    byte_i,
    input  logic [`LSU_XLEN-1:0]    wdata_i,
    output logic [`LSU_XLEN-1:0]    rdata_o,
    output logic [1:0]              bad_o,
    output logic                    xstate_o,
    output logic                    busy_o
);

    logic [7:0]     mem [0:2047];
    logic           resv_v;
    logic [28:0]    resv_a;
    integer         seed = 32'hc9b6_804b;

    initial begin
        int a;
        int v;
        for (a = 0; a < 2048; a++) begin
            v = a * 157 + (a >> 8) * 53;
            mem[a] = v[7:0];
        end
    end

    // Random stall level, independent of the traffic.
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy_o <= 1'b0;
        end else begin
            busy_o <= stall_en_i && (($random(seed) & 3) == 0);
        end
    end

    always @(posedge clk or negedge rstn) begin
        int i;
        logic [10:0] base;
        logic ok;
        if (!rstn) begin
            rdata_o  <= '0;
            bad_o    <= 2'd0;
            xstate_o <= 1'b0;
            resv_v   <= 1'b0;
            resv_a   <= '0;
        end else if (req_i) begin
            base = {addr_i[10:3], 3'b000};
            for (i = 0; i < 8; i++) begin
                rdata_o[8*i +: 8] <= mem[base + 11'(i)];
            end
            xstate_o <= 1'b0;
            if (addr_i[31:28] == 4'hf) begin
                // Upper half of the region gives access faults.
                bad_o <= addr_i[27] ? 2'd2 : 2'd1;
            end else begin
                bad_o <= 2'd0;
                if (wr_i) begin
                    ok = !ex_i || (resv_v && resv_a == addr_i[31:3]);
                    if (ex_i && ok) begin
                        xstate_o <= 1'b1;
                        resv_v   <= 1'b0;
                    end
                    if (ok) begin
                        for (i = 0; i < 8; i++) begin
                            if (byte_i[i]) begin
                                mem[base + 11'(i)] = wdata_i[8*i +: 8];
                            end
                        end
                    end
                end else if (ex_i) begin
                    resv_v <= 1'b1;
                    resv_a <= addr_i[31:3];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_cfg.svh"

module lsu_tb;

    localparam int MAX_CYCLES = 20000;

    logic                   clk;
    logic                   rstn;
    logic                   req_i;
    logic                   wr_i;
    logic                   ex_i;
    logic                   amo_i;
    logic                   amo_64_i;
    logic                   sign_ext_i;
    logic [`AMO_OP_LEN-1:0] amo_op_i;
    logic [`LSU_BLEN-1:0]   byte_i;
    logic [`LSU_ALEN-1:0]   addr_i;
    logic [`LSU_XLEN-1:0]   wdata_i;
    logic                   stall_en;

    logic                   amo_wr_o;
    logic [`LSU_XLEN-1:0]   rdata_o;
    logic                   hazard_o;
    logic                   fault_o;
    logic                   load_misaligned_o;
    logic                   store_misaligned_o;
    logic                   load_pg_fault_o;
    logic                   store_pg_fault_o;
    logic                   load_xes_fault_o;
    logic                   store_xes_fault_o;
    logic                   dmem_req_o;
    logic [`LSU_ALEN-1:0]   dmem_addr_o;
    logic                   dmem_wr_o;
    logic                   dmem_ex_o;
    logic [`LSU_BLEN-1:0]   dmem_byte_o;
    logic [`LSU_XLEN-1:0]   dmem_wdata_o;
    logic [`LSU_XLEN-1:0]   dmem_rdata;
    logic [1:0]             dmem_bad;
    logic                   dmem_xstate;
    logic                   dmem_busy;

    logic [7:0]             ref_mem [0:2047];
    logic [7:0]             last_be;
    logic                   last_amo;
    int                     cycles = 0;
    int                     req_cnt = 0;
    int                     wr_cnt = 0;
    int                     seed;

    lsu_top DUT (
        .clk(clk), .rstn(rstn), .req_i(req_i), .wr_i(wr_i), .ex_i(ex_i), .amo_i(amo_i),
        .amo_64_i(amo_64_i), .sign_ext_i(sign_ext_i), .amo_op_i(amo_op_i),
        .byte_i(byte_i), .addr_i(addr_i), .wdata_i(wdata_i),
        .amo_wr_o(amo_wr_o), .rdata_o(rdata_o), .hazard_o(hazard_o), .fault_o(fault_o),
        .load_misaligned_o(load_misaligned_o), .store_misaligned_o(store_misaligned_o),
        .load_pg_fault_o(load_pg_fault_o), .store_pg_fault_o(store_pg_fault_o),
        .load_xes_fault_o(load_xes_fault_o), .store_xes_fault_o(store_xes_fault_o),
        .dmem_req_o(dmem_req_o), .dmem_addr_o(dmem_addr_o), .dmem_wr_o(dmem_wr_o),
        .dmem_ex_o(dmem_ex_o), .dmem_byte_o(dmem_byte_o), .dmem_wdata_o(dmem_wdata_o),
        .dmem_rdata_i(dmem_rdata), .dmem_bad_i(dmem_bad), .dmem_xstate_i(dmem_xstate),
        .dmem_busy_i(dmem_busy)
    );

    dmem_model u_mem (
        .clk(clk), .rstn(rstn), .stall_en_i(stall_en), .req_i(dmem_req_o),
        .addr_i(dmem_addr_o), .wr_i(dmem_wr_o), .ex_i(dmem_ex_o), .byte_i(dmem_byte_o),
        .wdata_i(dmem_wdata_o), .rdata_o(dmem_rdata), .bad_o(dmem_bad),
        .xstate_o(dmem_xstate), .busy_o(dmem_busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Bus monitor and watchdog.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (dmem_req_o) begin
            req_cnt = req_cnt + 1;
            if (dmem_wr_o) begin
                wr_cnt   = wr_cnt + 1;
                last_be  = dmem_byte_o;
                last_amo = amo_wr_o;
            end
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "stopped by the watchdog");
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [7:0] fill_byte(input int a);
        int v;
        v = a * 157 + (a >> 8) * 53;
        return v[7:0];
    endfunction

    function automatic logic [7:0] size_mask(input int n);
        int m;
        m = (1 << n) - 1;
        return m[7:0];
    endfunction

    function automatic logic [63:0] ref_read(input int a, input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[a + i];
        end
        return v;
    endfunction

    task automatic ref_write(input int a, input int n, input logic [63:0] v);
        for (int i = 0; i < n; i++) begin
            ref_mem[a + i] = v[8*i +: 8];
        end
    endtask

    function automatic logic [63:0] extend(input logic [63:0] v, input int n, input logic sx);
        logic [63:0] m;
        logic [63:0] r;
        m = (n == 8) ? '1 : ((64'd1 << (8 * n)) - 64'd1);
        r = v & m;
        if (sx && n < 8 && v[8*n-1]) begin
            r = r | ~m;
        end
        return r;
    endfunction

    function automatic logic [63:0] amo_result(input logic [3:0] op, input logic [63:0] a_in,
                                               input logic [63:0] b_in, input logic is64);
        logic [63:0] a;
        logic [63:0] b;
        logic        lt_u;
        a = is64 ? a_in : {{32{a_in[31]}}, a_in[31:0]};
        b = is64 ? b_in : {{32{b_in[31]}}, b_in[31:0]};
        lt_u = is64 ? (a < b) : (a[31:0] < b[31:0]);
        case (op)
            `AMO_ADD:  return a + b;
            `AMO_XOR:  return a ^ b;
            `AMO_AND:  return a & b;
            `AMO_OR:   return a | b;
            `AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            `AMO_MAX:  return ($signed(a) < $signed(b)) ? b : a;
            `AMO_MINU: return lt_u ? a : b;
            `AMO_MAXU: return lt_u ? b : a;
            default:   return b;
        endcase
    endfunction

    task automatic issue_req(input logic wr, input logic ex, input logic amo, input logic a64,
                             input logic sx, input logic [3:0] op, input logic [7:0] be,
                             input int addr, input logic [63:0] data);
        @(posedge clk);
        req_i      <= 1'b1;
        wr_i       <= wr;
        ex_i       <= ex;
        amo_i      <= amo;
        amo_64_i   <= a64;
        sign_ext_i <= sx;
        amo_op_i   <= op;
        byte_i     <= be;
        addr_i     <= addr;
        wdata_i    <= data;
    endtask

    task automatic wait_resp();
        do begin
            @(negedge clk);
        end while (hazard_o);
    endtask

    task automatic release_req();
        @(posedge clk);
        req_i <= 1'b0;
    endtask

    task automatic load_check(input int addr, input int n, input logic sx, input logic ex);
        issue_req(1'b0, ex, 1'b0, 1'b0, sx, `AMO_SWAP, size_mask(n), addr, '0);
        wait_resp();
        check_value("rdata_o", rdata_o, extend(ref_read(addr, n), n, sx));
        check_value("fault_o", fault_o, 0);
        release_req();
    endtask

    task automatic store_check(input int addr, input int n, input logic [63:0] data);
        int wc;
        wc = wr_cnt;
        issue_req(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, `AMO_SWAP, size_mask(n), addr, data);
        wait_resp();
        check_value("write count", wr_cnt, wc + 1);
        check_value("dmem_byte_o", last_be, 8'(size_mask(n) << (addr % 8)));
        check_value("amo_wr_o", last_amo, 0);
        release_req();
        ref_write(addr, n, data);
        load_check(addr & ~7, 8, 1'b0, 1'b0);
    endtask

    task automatic misaligned_check(input logic wr, input int addr, input int n);
        int rc;
        rc = req_cnt;
        issue_req(wr, 1'b0, 1'b0, 1'b0, 1'b0, `AMO_SWAP, size_mask(n), addr,
                  64'h5a5a_a5a5_5a5a_a5a5);
        @(negedge clk);
        check_value("hazard_o", hazard_o, 0);
        check_value("fault_o", fault_o, 0);
        release_req();
        @(negedge clk);
        check_value("load_misaligned_o", load_misaligned_o, !wr);
        check_value("store_misaligned_o", store_misaligned_o, wr);
        check_value("fault_o", fault_o, 1);
        check_value("request count", req_cnt, rc);
        load_check(addr & ~7, 8, 1'b0, 1'b0);
    endtask

    task automatic amo_check(input logic [3:0] op, input logic a64, input int addr,
                             input logic [63:0] opnd);
        int n;
        int wc;
        logic [63:0] old;
        n   = a64 ? 8 : 4;
        old = ref_read(addr, n);
        wc  = wr_cnt;
        issue_req(1'b0, 1'b0, 1'b1, a64, 1'b1, op, size_mask(n), addr, opnd);
        wait_resp();
        check_value("rdata_o", rdata_o, extend(old, n, 1'b1));
        check_value("write count", wr_cnt, wc + 1);
        check_value("amo_wr_o", last_amo, 1);
        release_req();
        ref_write(addr, n, amo_result(op, old, opnd, a64));
        load_check(addr & ~7, 8, 1'b0, 1'b0);
    endtask

    task automatic sc_check(input int addr, input logic [63:0] data, input logic fail);
        issue_req(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, `AMO_SWAP, 8'hff, addr, data);
        wait_resp();
        check_value("rdata_o", rdata_o, {63'd0, fail});
        release_req();
        if (!fail) begin
            ref_write(addr, 8, data);
        end
        load_check(addr, 8, 1'b0, 1'b0);
    endtask

    task automatic fault_check(input logic wr, input logic amo, input int addr, input int code);
        int wc;
        logic st;
        wc = wr_cnt;
        st = wr | amo;
        issue_req(wr, 1'b0, amo, 1'b1, 1'b0, `AMO_ADD, 8'hff, addr, 64'h1);
        wait_resp();
        check_value("load_pg_fault_o", load_pg_fault_o, !st && code == 1);
        check_value("store_pg_fault_o", store_pg_fault_o, st && code == 1);
        check_value("load_xes_fault_o", load_xes_fault_o, !st && code == 2);
        check_value("store_xes_fault_o", store_xes_fault_o, st && code == 2);
        check_value("fault_o", fault_o, 1);
        if (amo) begin
            check_value("write count", wr_cnt, wc);
        end
        release_req();
    endtask

    task automatic loads_all_offsets(input int base);
        for (int n = 1; n <= 8; n = n * 2) begin
            for (int off = 0; off < 8; off += n) begin
                load_check(base + off, n, 1'b0, 1'b0);
                load_check(base + off, n, 1'b1, 1'b0);
            end
        end
    endtask

    task automatic stores_all_offsets(input int base);
        logic [63:0] d;
        for (int n = 1; n <= 8; n = n * 2) begin
            for (int off = 0; off < 8; off += n) begin
                d = {$random(seed), $random(seed)};
                store_check(base + off, n, d);
            end
        end
    endtask

    task automatic misaligned_cases();
        misaligned_check(1'b0, 32'h101, 2);
        misaligned_check(1'b0, 32'h102, 4);
        misaligned_check(1'b0, 32'h104, 8);
        misaligned_check(1'b1, 32'h301, 2);
        misaligned_check(1'b1, 32'h306, 4);
        misaligned_check(1'b1, 32'h304, 8);
    endtask

    task automatic atomic_ops();
        for (int op = 0; op <= 8; op++) begin
            amo_check(op[3:0], 1'b0, 32'h400, {$random(seed), $random(seed)});
            amo_check(op[3:0], 1'b0, 32'h404, {$random(seed), $random(seed)});
            amo_check(op[3:0], 1'b1, 32'h408, {$random(seed), $random(seed)});
        end
    endtask

    task automatic reservation_cases();
        load_check(32'h500, 8, 1'b0, 1'b1);
        sc_check(32'h508, 64'h1111_2222_3333_4444, 1'b1);
        sc_check(32'h500, 64'h5555_6666_7777_8888, 1'b0);
        sc_check(32'h500, 64'h9999_aaaa_bbbb_cccc, 1'b1);
    endtask

    task automatic fault_regions();
        fault_check(1'b0, 1'b0, 32'hf000_0010, 1);
        fault_check(1'b0, 1'b0, 32'hf800_0020, 2);
        fault_check(1'b1, 1'b0, 32'hf000_0018, 1);
        fault_check(1'b1, 1'b0, 32'hf800_0028, 2);
        fault_check(1'b0, 1'b1, 32'hf000_0030, 1);
        fault_check(1'b0, 1'b1, 32'hf800_0038, 2);
    endtask

    initial begin
        seed       = 32'hc9b6_804b;
        rstn       = 1'b0;
        req_i      = 1'b0;
        wr_i       = 1'b0;
        ex_i       = 1'b0;
        amo_i      = 1'b0;
        amo_64_i   = 1'b0;
        sign_ext_i = 1'b0;
        amo_op_i   = '0;
        byte_i     = '0;
        addr_i     = '0;
        wdata_i    = '0;
        stall_en   = 1'b0;
        last_be    = '0;
        last_amo   = 1'b0;
        for (int a = 0; a < 2048; a++) begin
            ref_mem[a] = fill_byte(a);
        end
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_value("hazard_o", hazard_o, 0);
        check_value("dmem_req_o", dmem_req_o, 0);
        check_value("amo_wr_o", amo_wr_o, 0);
        check_value("fault_o", fault_o, 0);

        loads_all_offsets(32'h100);
        @(posedge clk);
        stall_en <= 1'b1;
        loads_all_offsets(32'h238);
        stores_all_offsets(32'h300);
        misaligned_cases();
        atomic_ops();
        reservation_cases();
        fault_regions();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/lsu_pkg.sv
source/lsu_ctrl.sv
source/store_align.sv
source/load_align.sv
source/amo_alu.sv
source/lsu_top.sv
tests/dmem_model.sv
tests/lsu_tb.sv

// File: Makefile
SRCS := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: run clean

obj_dir/Vlsu_tb: $(SRCS) all.f
	verilator --binary --timing -f all.f --top-module lsu_tb -Mdir obj_dir -o Vlsu_tb

run: obj_dir/Vlsu_tb
	-./obj_dir/Vlsu_tb > sim.log 2>&1
	cat sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
